/* mipsPkg.sv */
package mipsPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [3:0]  aluOp_t;
    typedef logic [2:0]  lsType_t;
    typedef logic [2:0]  brType_t;
    typedef logic [4:0]  excCode_t;

    // ALU operations, as produced by the decoder
    localparam aluOp_t ALU_ADD  = 4'd0;
    localparam aluOp_t ALU_ADDU = 4'd1;
    localparam aluOp_t ALU_SUB  = 4'd2;
    localparam aluOp_t ALU_SUBU = 4'd3;
    localparam aluOp_t ALU_AND  = 4'd4;
    localparam aluOp_t ALU_OR   = 4'd5;
    localparam aluOp_t ALU_XOR  = 4'd6;
    localparam aluOp_t ALU_NOR  = 4'd7;
    localparam aluOp_t ALU_SLT  = 4'd8;
    localparam aluOp_t ALU_SLTU = 4'd9;
    localparam aluOp_t ALU_SLL  = 4'd10;
    localparam aluOp_t ALU_SRL  = 4'd11;
    localparam aluOp_t ALU_SRA  = 4'd12;
    localparam aluOp_t ALU_LUI  = 4'd13;

    // Access width and sign of loads and stores
    localparam lsType_t LS_BYTE  = 3'd0;
    localparam lsType_t LS_BYTEU = 3'd1;
    localparam lsType_t LS_HALF  = 3'd2;
    localparam lsType_t LS_HALFU = 3'd3;
    localparam lsType_t LS_WORD  = 3'd4;

    localparam brType_t BR_EQ  = 3'd0;
    localparam brType_t BR_NE  = 3'd1;
    localparam brType_t BR_LEZ = 3'd2;
    localparam brType_t BR_GTZ = 3'd3;
    localparam brType_t BR_LTZ = 3'd4;
    localparam brType_t BR_GEZ = 3'd5;

    // Cause register codes
    localparam excCode_t EXC_ADEL = 5'd4;
    localparam excCode_t EXC_ADES = 5'd5;
    localparam excCode_t EXC_SYS  = 5'd8;
    localparam excCode_t EXC_BP   = 5'd9;
    localparam excCode_t EXC_RI   = 5'd10;
    localparam excCode_t EXC_OV   = 5'd12;

endpackage

/* aluUnit.sv */
module aluUnit (
    input  mipsPkg::word_t  srcA,
    input  mipsPkg::word_t  srcB,
    input  logic [4:0]      shamt,
    input  mipsPkg::aluOp_t aluOp,
    output mipsPkg::word_t  aluResult,
    output logic            overflow
);
    import mipsPkg::*;

    word_t sum;
    word_t diff;

    assign sum  = srcA + srcB;
    assign diff = srcA - srcB;

    always_comb begin
        case (aluOp)
            ALU_ADD, ALU_ADDU: begin
                aluResult = sum;
            end
            ALU_SUB, ALU_SUBU: begin
                aluResult = diff;
            end
            ALU_AND:  aluResult = srcA & srcB;
            ALU_OR:   aluResult = srcA | srcB;
            ALU_XOR:  aluResult = srcA ^ srcB;
            ALU_NOR:  aluResult = ~(srcA | srcB);
            ALU_SLT:  aluResult = {31'd0, $signed(srcA) < $signed(srcB)};
            ALU_SLTU: aluResult = {31'd0, srcA < srcB};
            // Shifts operate on rt, which arrives on srcB
            ALU_SLL:  aluResult = srcB << shamt;
            ALU_SRL:  aluResult = srcB >> shamt;
            ALU_SRA:  aluResult = word_t'($signed(srcB) >>> shamt);
            ALU_LUI:  aluResult = {srcB[15:0], 16'd0};
            default:  aluResult = '0;
        endcase
    end

    // Only the trapping forms report overflow
    always_comb begin
        case (aluOp)
            ALU_ADD: begin
                overflow = (srcA[31] == srcB[31]) && (sum[31] != srcA[31]);
            end
            ALU_SUB: begin
                overflow = (srcA[31] != srcB[31]) && (diff[31] != srcA[31]);
            end
            default: begin
                overflow = 1'b0;
            end
        endcase
    end

endmodule

/* branchResolve.sv */
module branchResolve (
    input  logic             branch,
    input  mipsPkg::brType_t brType,
    input  mipsPkg::word_t   srcA,
    input  mipsPkg::word_t   srcB,
    input  mipsPkg::word_t   pcE,
    input  mipsPkg::word_t   branchOffset,
    output logic             actualTake,
    output mipsPkg::word_t   pcBranch
);
    import mipsPkg::*;

    logic  condMet;
    logic  aIsZero;
    word_t offsetBytes;

    assign aIsZero = (srcA == '0);

    always_comb begin
        case (brType)
            BR_EQ:   condMet = (srcA == srcB);
            BR_NE:   condMet = (srcA != srcB);
            BR_LEZ:  condMet = srcA[31] || aIsZero;
            BR_GTZ:  condMet = !srcA[31] && !aIsZero;
            BR_LTZ:  condMet = srcA[31];
            BR_GEZ:  condMet = !srcA[31];
            default: condMet = 1'b0;
        endcase
    end

    assign actualTake = branch && condMet;

    // Offset counts instructions and is relative to the delay slot
    assign offsetBytes = {branchOffset[29:0], 2'b00};
    assign pcBranch    = pcE + 32'd4 + offsetBytes;

endmodule

/* exMem.sv */
module exMem (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              stall,
    input  mipsPkg::word_t    pcE,
    input  mipsPkg::word_t    instrE,
    input  mipsPkg::word_t    aluResultE,
    input  mipsPkg::word_t    rtValueE,
    input  mipsPkg::word_t    pcBranchE,
    input  mipsPkg::regAddr_t regWriteAddrE,
    input  mipsPkg::lsType_t  lsTypeE,
    input  logic              branchE,
    input  logic              predTakeE,
    input  logic              actualTakeE,
    input  logic              overflowE,
    input  logic              inDelaySlotE,
    input  logic              regWriteEnE,
    input  logic              memReadEnE,
    input  logic              memWriteEnE,
    input  logic              memToRegE,
    input  logic              riE,
    input  logic              brkE,
    input  logic              syscallE,
    output mipsPkg::word_t    pcM,
    output mipsPkg::word_t    instrM,
    output mipsPkg::word_t    aluResultM,
    output mipsPkg::word_t    rtValueM,
    output mipsPkg::word_t    pcBranchM,
    output mipsPkg::regAddr_t regWriteAddrM,
    output mipsPkg::lsType_t  lsTypeM,
    output logic              branchM,
    output logic              predTakeM,
    output logic              actualTakeM,
    output logic              overflowM,
    output logic              inDelaySlotM,
    output logic              regWriteEnM,
    output logic              memReadEnM,
    output logic              memWriteEnM,
    output logic              memToRegM,
    output logic              riM,
    output logic              brkM,
    output logic              syscallM
);

    logic [11:0] ctrlM;

    // Flush wins over stall and inserts a zero bubble
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            pcM           <= '0;
            instrM        <= '0;
            aluResultM    <= '0;
            rtValueM      <= '0;
            pcBranchM     <= '0;
            regWriteAddrM <= '0;
            lsTypeM       <= '0;
            ctrlM         <= '0;
        end else if (!stall) begin
            pcM           <= pcE;
            instrM        <= instrE;
            aluResultM    <= aluResultE;
            rtValueM      <= rtValueE;
            pcBranchM     <= pcBranchE;
            regWriteAddrM <= regWriteAddrE;
            lsTypeM       <= lsTypeE;
            ctrlM         <= {branchE, predTakeE, actualTakeE, overflowE, inDelaySlotE,
                              regWriteEnE, memReadEnE, memWriteEnE, memToRegE,
                              riE, brkE, syscallE};
        end
    end

    assign {branchM, predTakeM, actualTakeM, overflowM, inDelaySlotM, regWriteEnM,
            memReadEnM, memWriteEnM, memToRegM, riM, brkM, syscallM} = ctrlM;

    // A bubble leaves no control bit set for the M stage
    bubbleAfterClear: assert property (@(posedge clk) (reset || flush) |=> (ctrlM == '0))
        else $error("exMem control not cleared after reset or flush");

    holdUnderStall: assert property (@(posedge clk)
        (stall && !flush && !reset) |=>
            $stable({pcM, instrM, aluResultM, rtValueM, pcBranchM,
                     regWriteAddrM, lsTypeM, ctrlM}))
        else $error("exMem outputs changed while stalled");

endmodule

/* memStage.sv */
module memStage (
    input  mipsPkg::word_t    pcM,
    input  mipsPkg::word_t    aluResultM,
    input  mipsPkg::word_t    rtValueM,
    input  mipsPkg::word_t    pcBranchM,
    input  mipsPkg::regAddr_t regWriteAddrM,
    input  mipsPkg::lsType_t  lsTypeM,
    input  logic              branchM,
    input  logic              predTakeM,
    input  logic              actualTakeM,
    input  logic              overflowM,
    input  logic              inDelaySlotM,
    input  logic              regWriteEnM,
    input  logic              memReadEnM,
    input  logic              memWriteEnM,
    input  logic              memToRegM,
    input  logic              riM,
    input  logic              brkM,
    input  logic              syscallM,
    input  mipsPkg::word_t    memReadData,
    output mipsPkg::word_t    memAddr,
    output mipsPkg::word_t    memWriteData,
    output logic [3:0]        memByteEn,
    output logic              memReadReq,
    output logic              memWriteReq,
    output logic              wbEn,
    output mipsPkg::regAddr_t wbAddr,
    output mipsPkg::word_t    wbData,
    output logic              excValid,
    output mipsPkg::excCode_t excCode,
    output mipsPkg::word_t    excPc,
    output logic              mispredict,
    output mipsPkg::word_t    redirectPc
);
    import mipsPkg::*;

    logic [1:0] byteOff;
    logic [4:0] bitOff;
    logic       misaligned;
    logic [3:0] laneMask;
    word_t      laneData;
    word_t      loadData;

    assign byteOff = aluResultM[1:0];
    assign bitOff  = {byteOff, 3'b000};

    always_comb begin
        case (lsTypeM)
            LS_BYTE, LS_BYTEU: begin
                misaligned = 1'b0;
                laneMask   = 4'b0001;
            end
            LS_HALF, LS_HALFU: begin
                misaligned = byteOff[0];
                laneMask   = 4'b0011;
            end
            default: begin
                misaligned = (byteOff != 2'b00);
                laneMask   = 4'b1111;
            end
        endcase
    end

    // Highest priority first, address errors come last
    always_comb begin
        excValid = 1'b1;
        if (riM) begin
            excCode = EXC_RI;
        end else if (syscallM) begin
            excCode = EXC_SYS;
        end else if (brkM) begin
            excCode = EXC_BP;
        end else if (overflowM) begin
            excCode = EXC_OV;
        end else if (memReadEnM && misaligned) begin
            excCode = EXC_ADEL;
        end else if (memWriteEnM && misaligned) begin
            excCode = EXC_ADES;
        end else begin
            excValid = 1'b0;
            excCode  = '0;
        end
    end

    assign memAddr      = {aluResultM[31:2], 2'b00};
    assign memByteEn    = laneMask << byteOff;
    assign memWriteData = rtValueM << bitOff;
    assign memReadReq   = memReadEnM && !excValid;
    assign memWriteReq  = memWriteEnM && !excValid;

    // The addressed lane moves down to bit 0 before extension
    assign laneData = memReadData >> bitOff;

    always_comb begin
        case (lsTypeM)
            LS_BYTE:  loadData = {{24{laneData[7]}}, laneData[7:0]};
            LS_BYTEU: loadData = {24'd0, laneData[7:0]};
            LS_HALF:  loadData = {{16{laneData[15]}}, laneData[15:0]};
            LS_HALFU: loadData = {16'd0, laneData[15:0]};
            default:  loadData = laneData;
        endcase
    end

    assign wbEn   = regWriteEnM && !excValid;
    assign wbAddr = regWriteAddrM;
    assign wbData = memToRegM ? loadData : aluResultM;

    assign excPc = inDelaySlotM ? pcM - 32'd4 : pcM;

    assign mispredict = branchM && (predTakeM != actualTakeM);
    assign redirectPc = actualTakeM ? pcBranchM : pcM + 32'd8;

    // A single instruction never drives both directions of the bus
    always_comb begin
        busExclusive: assert (!(memReadReq && memWriteReq))
            else $error("memStage raised read and write requests together");
    end

endmodule

/* executeMemTop.sv */
module executeMemTop (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              stall,
    input  mipsPkg::word_t    pcE,
    input  mipsPkg::word_t    instrE,
    input  mipsPkg::word_t    srcA,
    input  mipsPkg::word_t    srcB,
    input  logic [4:0]        shamt,
    input  mipsPkg::aluOp_t   aluOp,
    input  logic              branch,
    input  mipsPkg::brType_t  brType,
    input  logic              predTake,
    input  mipsPkg::word_t    branchOffset,
    input  logic              inDelaySlot,
    input  mipsPkg::regAddr_t regWriteAddr,
    input  logic              regWriteEn,
    input  logic              memReadEn,
    input  logic              memWriteEn,
    input  logic              memToReg,
    input  mipsPkg::lsType_t  lsType,
    input  mipsPkg::word_t    rtValue,
    input  logic              ri,
    input  logic              brk,
    input  logic              syscall,
    input  mipsPkg::word_t    memReadData,
    output mipsPkg::word_t    memAddr,
    output logic [3:0]        memByteEn,
    output mipsPkg::word_t    memWriteData,
    output logic              memReadReq,
    output logic              memWriteReq,
    output logic              wbEn,
    output mipsPkg::regAddr_t wbAddr,
    output mipsPkg::word_t    wbData,
    output logic              excValid,
    output mipsPkg::excCode_t excCode,
    output mipsPkg::word_t    excPc,
    output logic              mispredict,
    output mipsPkg::word_t    redirectPc
);
    import mipsPkg::*;

    word_t    aluResult;
    word_t    pcBranch;
    logic     overflow;
    logic     actualTake;

    word_t    pcM, aluResultM, rtValueM, pcBranchM;
    regAddr_t regWriteAddrM;
    lsType_t  lsTypeM;
    logic     branchM, predTakeM, actualTakeM, overflowM, inDelaySlotM;
    logic     regWriteEnM, memReadEnM, memWriteEnM, memToRegM;
    logic     riM, brkM, syscallM;

    aluUnit aluUnit_i (
        .srcA,
        .srcB,
        .shamt,
        .aluOp,
        .aluResult,
        .overflow
    );

    branchResolve branchResolve_i (
        .branch,
        .brType,
        .srcA,
        .srcB,
        .pcE,
        .branchOffset,
        .actualTake,
        .pcBranch
    );

    // The instruction word rides along for debug only
    exMem exMem_i (
        .clk,
        .reset,
        .flush,
        .stall,
        .pcE,
        .instrE,
        .aluResultE    (aluResult),
        .rtValueE      (rtValue),
        .pcBranchE     (pcBranch),
        .regWriteAddrE (regWriteAddr),
        .lsTypeE       (lsType),
        .branchE       (branch),
        .predTakeE     (predTake),
        .actualTakeE   (actualTake),
        .overflowE     (overflow),
        .inDelaySlotE  (inDelaySlot),
        .regWriteEnE   (regWriteEn),
        .memReadEnE    (memReadEn),
        .memWriteEnE   (memWriteEn),
        .memToRegE     (memToReg),
        .riE           (ri),
        .brkE          (brk),
        .syscallE      (syscall),
        .pcM,
        .instrM        (),
        .aluResultM,
        .rtValueM,
        .pcBranchM,
        .regWriteAddrM,
        .lsTypeM,
        .branchM,
        .predTakeM,
        .actualTakeM,
        .overflowM,
        .inDelaySlotM,
        .regWriteEnM,
        .memReadEnM,
        .memWriteEnM,
        .memToRegM,
        .riM,
        .brkM,
        .syscallM
    );

    memStage memStage_i (
        .pcM,
        .aluResultM,
        .rtValueM,
        .pcBranchM,
        .regWriteAddrM,
        .lsTypeM,
        .branchM,
        .predTakeM,
        .actualTakeM,
        .overflowM,
        .inDelaySlotM,
        .regWriteEnM,
        .memReadEnM,
        .memWriteEnM,
        .memToRegM,
        .riM,
        .brkM,
        .syscallM,
        .memReadData,
        .memAddr,
        .memWriteData,
        .memByteEn,
        .memReadReq,
        .memWriteReq,
        .wbEn,
        .wbAddr,
        .wbData,
        .excValid,
        .excCode,
        .excPc,
        .mispredict,
        .redirectPc
    );

endmodule

/* tbExecuteMem.sv */
module tbExecuteMem;
    import mipsPkg::*;

    typedef struct {
        word_t    pc, srcA, srcB, offset, rtValue;
        logic [4:0] shamt;
        aluOp_t   aluOp;
        brType_t  brType;
        lsType_t  lsType;
        regAddr_t rd;
        logic branch, predTake, inDelaySlot, regWriteEn, memReadEn, memWriteEn;
        logic memToReg, ri, brk, syscall, stall, flush;
    } stimRow_t;

    logic clk, reset, flush, stall;
    word_t pcE, instrE, srcA, srcB, branchOffset, rtValue, memReadData;
    logic [4:0] shamt;
    aluOp_t aluOp;
    brType_t brType;
    lsType_t lsType;
    regAddr_t regWriteAddr;
    logic branch, predTake, inDelaySlot, regWriteEn, memReadEn, memWriteEn, memToReg;
    logic ri, brk, syscall;
    word_t memAddr, memWriteData, wbData, excPc, redirectPc;
    logic [3:0] memByteEn;
    logic memReadReq, memWriteReq, wbEn, excValid, mispredict;
    regAddr_t wbAddr;
    excCode_t excCode;

    word_t dataMem [64];
    word_t refMem [64];
    stimRow_t stimTable [$];
    stimRow_t mReg;
    int errorCount = 0;
    int checkCount = 0;
    logic tableReady = 1'b0;

    executeMemTop executeMemTop_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Data memory with asynchronous read and byte-enabled write
    assign memReadData = dataMem[memAddr[7:2]];
    always @(posedge clk) begin
        if (memWriteReq) begin
            for (int b = 0; b < 4; b++) begin
                if (memByteEn[b]) dataMem[memAddr[7:2]][8*b +: 8] <= memWriteData[8*b +: 8];
            end
        end
    end

    function automatic stimRow_t blankRow();
        stimRow_t r;
        r = '{default: '0};
        return r;
    endfunction

    task automatic addRow(stimRow_t r);
        r.pc = 32'h0040_0000 + 32'(stimTable.size() * 4);
        stimTable.push_back(r);
    endtask

    task automatic aluRow(aluOp_t op, word_t a, word_t b, logic [4:0] sh);
        stimRow_t r;
        r = blankRow();
        r.aluOp = op;
        r.srcA = a;
        r.srcB = b;
        r.shamt = sh;
        r.regWriteEn = 1'b1;
        r.rd = 5'(op + 1);
        addRow(r);
    endtask

    task automatic memRow(logic isStore, lsType_t ls, word_t addr, word_t data);
        stimRow_t r;
        r = blankRow();
        r.aluOp = ALU_ADDU;
        r.srcA = addr & 32'hFFFF_FFF0;
        r.srcB = addr & 32'h0000_000F;
        r.lsType = ls;
        r.rtValue = data;
        r.memWriteEn = isStore;
        r.memReadEn = !isStore;
        r.memToReg = !isStore;
        r.regWriteEn = !isStore;
        r.rd = 5'd9;
        addRow(r);
    endtask

    task automatic buildTable();
        stimRow_t r;
        aluRow(ALU_ADD, 32'd5, 32'd7, 0);
        aluRow(ALU_ADDU, 32'hFFFF_FFFF, 32'd2, 0);
        aluRow(ALU_SUB, 32'd10, 32'd3, 0);
        aluRow(ALU_SUBU, 32'd3, 32'd10, 0);
        aluRow(ALU_AND, 32'hF0F0_1234, 32'h0FF0_FF00, 0);
        aluRow(ALU_OR, 32'hF0F0_1234, 32'h0FF0_FF00, 0);
        aluRow(ALU_XOR, 32'hF0F0_1234, 32'h0FF0_FF00, 0);
        aluRow(ALU_NOR, 32'hF0F0_1234, 32'h0FF0_FF00, 0);
        aluRow(ALU_SLT, 32'hFFFF_FFFF, 32'd1, 0);
        aluRow(ALU_SLTU, 32'hFFFF_FFFF, 32'd1, 0);
        aluRow(ALU_SLL, 32'd0, 32'h8000_00F1, 5'd4);
        aluRow(ALU_SRL, 32'd0, 32'h8000_00F1, 5'd4);
        aluRow(ALU_SRA, 32'd0, 32'h8000_00F1, 5'd4);
        aluRow(ALU_LUI, 32'd0, 32'h0000_BEEF, 0);
        // Signed overflow on the trapping forms only
        aluRow(ALU_ADD, 32'h7FFF_FFFF, 32'd1, 0);
        aluRow(ALU_ADDU, 32'h7FFF_FFFF, 32'd1, 0);
        aluRow(ALU_SUB, 32'h8000_0000, 32'd1, 0);
        for (int k = 0; k < 4; k++) memRow(1'b1, LS_BYTE, 32'h40 + k, 32'hA5 + k);
        memRow(1'b1, LS_HALF, 32'h50, 32'h0000_8001);
        memRow(1'b1, LS_HALF, 32'h52, 32'h0000_7FFE);
        memRow(1'b1, LS_WORD, 32'h60, 32'hDEAD_BEEF);
        memRow(1'b0, LS_BYTE, 32'h41, 0);
        memRow(1'b0, LS_BYTEU, 32'h43, 0);
        memRow(1'b0, LS_HALF, 32'h50, 0);
        memRow(1'b0, LS_HALFU, 32'h52, 0);
        memRow(1'b0, LS_HALFU, 32'h50, 0);
        memRow(1'b0, LS_WORD, 32'h60, 0);
        memRow(1'b0, LS_WORD, 32'h84, 0);
        memRow(1'b0, LS_HALF, 32'h51, 0);
        memRow(1'b0, LS_WORD, 32'h62, 0);
        memRow(1'b1, LS_HALF, 32'h53, 32'h1111);
        memRow(1'b1, LS_WORD, 32'h61, 32'h2222);
        for (int t = 0; t < 6; t++) begin
            for (int p = 0; p < 2; p++) begin
                r = blankRow();
                r.branch = 1'b1;
                r.brType = brType_t'(t);
                r.predTake = p[0];
                r.srcA = t[0] ? 32'hFFFF_FFF8 : (p[0] ? 32'd0 : 32'd5);
                r.srcB = 32'd5;
                r.offset = word_t'(t * 4 - 3);
                addRow(r);
            end
        end
        for (int e = 1; e < 8; e++) begin
            r = blankRow();
            r.ri = e[0];
            r.syscall = e[1];
            r.brk = e[2];
            r.inDelaySlot = e[1];
            r.regWriteEn = 1'b1;
            addRow(r);
        end
        r = blankRow();
        r.aluOp = ALU_ADD;
        r.srcA = 32'h8000_0000;
        r.srcB = 32'h8000_0001;
        r.memReadEn = 1'b1;
        r.lsType = LS_WORD;
        addRow(r);
        r.brk = 1'b1;
        addRow(r);
        // Stall holds the previous instruction, flush overrides stall
        aluRow(ALU_OR, 32'h1234_0000, 32'h0000_5678, 0);
        r = blankRow();
        r.stall = 1'b1;
        r.aluOp = ALU_XOR;
        r.srcA = 32'hFFFF_0000;
        r.regWriteEn = 1'b1;
        addRow(r);
        addRow(r);
        r.flush = 1'b1;
        addRow(r);
        aluRow(ALU_ADD, 32'd1, 32'd2, 0);
        r = blankRow();
        r.flush = 1'b1;
        addRow(r);
    endtask

    task automatic driveRow(stimRow_t r);
        pcE <= r.pc;
        instrE <= r.pc ^ 32'h2400_0000;
        srcA <= r.srcA;
        srcB <= r.srcB;
        shamt <= r.shamt;
        aluOp <= r.aluOp;
        branch <= r.branch;
        brType <= r.brType;
        predTake <= r.predTake;
        branchOffset <= r.offset;
        inDelaySlot <= r.inDelaySlot;
        regWriteAddr <= r.rd;
        regWriteEn <= r.regWriteEn;
        memReadEn <= r.memReadEn;
        memWriteEn <= r.memWriteEn;
        memToReg <= r.memToReg;
        lsType <= r.lsType;
        rtValue <= r.rtValue;
        ri <= r.ri;
        brk <= r.brk;
        syscall <= r.syscall;
        stall <= r.stall;
        flush <= r.flush;
    endtask

    function automatic word_t aluModel(stimRow_t r);
        case (r.aluOp)
            ALU_ADD, ALU_ADDU: return r.srcA + r.srcB;
            ALU_SUB, ALU_SUBU: return r.srcA - r.srcB;
            ALU_AND:  return r.srcA & r.srcB;
            ALU_OR:   return r.srcA | r.srcB;
            ALU_XOR:  return r.srcA ^ r.srcB;
            ALU_NOR:  return ~(r.srcA | r.srcB);
            ALU_SLT:  return ($signed(r.srcA) < $signed(r.srcB)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (r.srcA < r.srcB) ? 32'd1 : 32'd0;
            ALU_SLL:  return r.srcB << r.shamt;
            ALU_SRL:  return r.srcB >> r.shamt;
            ALU_SRA:  return word_t'($signed(r.srcB) >>> r.shamt);
            ALU_LUI:  return {r.srcB[15:0], 16'h0000};
            default:  return '0;
        endcase
    endfunction

    function automatic logic overflowModel(stimRow_t r);
        longint wide;
        wide = longint'($signed(r.srcA));
        if (r.aluOp == ALU_ADD) wide = wide + longint'($signed(r.srcB));
        else if (r.aluOp == ALU_SUB) wide = wide - longint'($signed(r.srcB));
        else return 1'b0;
        return (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
    endfunction

    task automatic checkValue(string name, word_t expected, word_t actual);
        checkCount++;
        assert (expected === actual) else begin
            errorCount++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkOutputs();
        word_t res, lane, loadVal, mask, target;
        logic ovf, mis, cond, take, anyExc;
        logic [3:0] be;
        logic [4:0] sh;
        excCode_t code;
        res = aluModel(mReg);
        ovf = overflowModel(mReg);
        sh = {res[1:0], 3'b000};
        case (mReg.lsType)
            LS_BYTE, LS_BYTEU: begin
                mis = 1'b0;
                be = 4'b0001 << res[1:0];
            end
            LS_HALF, LS_HALFU: begin
                mis = res[0];
                be = 4'b0011 << res[1:0];
            end
            default: begin
                mis = (res[1:0] != 2'b00);
                be = 4'b1111;
            end
        endcase
        anyExc = 1'b1;
        if (mReg.ri) code = EXC_RI;
        else if (mReg.syscall) code = EXC_SYS;
        else if (mReg.brk) code = EXC_BP;
        else if (ovf) code = EXC_OV;
        else if (mReg.memReadEn && mis) code = EXC_ADEL;
        else if (mReg.memWriteEn && mis) code = EXC_ADES;
        else anyExc = 1'b0;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        lane = refMem[res[7:2]] >> sh;
        case (mReg.lsType)
            LS_BYTE:  loadVal = {{24{lane[7]}}, lane[7:0]};
            LS_BYTEU: loadVal = {24'd0, lane[7:0]};
            LS_HALF:  loadVal = {{16{lane[15]}}, lane[15:0]};
            LS_HALFU: loadVal = {16'd0, lane[15:0]};
            default:  loadVal = lane;
        endcase
        case (mReg.brType)
            BR_EQ:   cond = (mReg.srcA == mReg.srcB);
            BR_NE:   cond = (mReg.srcA != mReg.srcB);
            BR_LEZ:  cond = ($signed(mReg.srcA) <= 0);
            BR_GTZ:  cond = ($signed(mReg.srcA) > 0);
            BR_LTZ:  cond = ($signed(mReg.srcA) < 0);
            BR_GEZ:  cond = ($signed(mReg.srcA) >= 0);
            default: cond = 1'b0;
        endcase
        take = mReg.branch && cond;
        target = mReg.pc + 32'd4 + (mReg.offset << 2);
        checkValue("memReadReq", word_t'(mReg.memReadEn && !anyExc), word_t'(memReadReq));
        checkValue("memWriteReq", word_t'(mReg.memWriteEn && !anyExc), word_t'(memWriteReq));
        checkValue("wbEn", word_t'(mReg.regWriteEn && !anyExc), word_t'(wbEn));
        checkValue("excValid", word_t'(anyExc), word_t'(excValid));
        checkValue("mispredict", word_t'(mReg.branch && (mReg.predTake != take)),
                   word_t'(mispredict));
        if ((mReg.memReadEn || mReg.memWriteEn) && !anyExc) begin
            checkValue("memAddr", {res[31:2], 2'b00}, memAddr);
        end
        if (mReg.memWriteEn && !anyExc) begin
            checkValue("memByteEn", word_t'(be), word_t'(memByteEn));
            checkValue("memWriteData", (mReg.rtValue << sh) & mask, memWriteData & mask);
            refMem[res[7:2]] = (refMem[res[7:2]] & ~mask) | ((mReg.rtValue << sh) & mask);
        end
        if (mReg.regWriteEn && !anyExc) begin
            checkValue("wbAddr", word_t'(mReg.rd), word_t'(wbAddr));
            checkValue("wbData", mReg.memToReg ? loadVal : res, wbData);
        end
        if (anyExc) begin
            checkValue("excCode", word_t'(code), word_t'(excCode));
            checkValue("excPc", mReg.inDelaySlot ? mReg.pc - 32'd4 : mReg.pc, excPc);
        end
        if (mReg.branch && (mReg.predTake != take)) begin
            checkValue("redirectPc", take ? target : mReg.pc + 32'd8, redirectPc);
        end
    endtask

    initial begin
        word_t seedWord;
        reset <= 1'b1;
        driveRow(blankRow());
        mReg = blankRow();
        void'($urandom(84));
        for (int i = 0; i < 64; i++) begin
            seedWord = $urandom;
            dataMem[i] = seedWord;
            refMem[i] = seedWord;
        end
        buildTable();
        tableReady = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkOutputs();
        for (int i = 0; i <= stimTable.size(); i++) begin
            @(posedge clk);
            if (i < stimTable.size()) driveRow(stimTable[i]);
            else driveRow(blankRow());
            @(negedge clk);
            if (i > 0) begin
                if (stimTable[i-1].flush) mReg = blankRow();
                else if (!stimTable[i-1].stall) mReg = stimTable[i-1];
                checkOutputs();
            end
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        wait (tableReady);
        #((stimTable.size() + 20) * 100);
        $display("Watchdog timeout: the stimulus table did not complete in time");
        $display("Regression failed");
        $finish;
    end

endmodule

/* executeMemTop.f */
mipsPkg.sv
aluUnit.sv
branchResolve.sv
exMem.sv
memStage.sv
executeMemTop.sv
tbExecuteMem.sv

/* Makefile */
# Verilator build and run for the execute and memory stage slice
VERILATOR ?= verilator
TOP       ?= tbExecuteMem
FILELIST  ?= executeMemTop.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASSTEXT  ?= Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)
